// ==== design/corePkg.sv ====
package corePkg;

	// Widths with a meaning of their own
	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;
	typedef logic [2:0] aluOpT;

	// First fetch address
	localparam wordT resetPc = 32'h0000_0000;

	// Major opcodes, instruction bits 6:0
	localparam logic [6:0] opRegReg = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;

	// ALU operations
	localparam aluOpT aluAdd = 3'd0;
	localparam aluOpT aluSub = 3'd1;
	localparam aluOpT aluAnd = 3'd2;
	localparam aluOpT aluOr = 3'd3;
	localparam aluOpT aluXor = 3'd4;
	localparam aluOpT aluSlt = 3'd5;

	// addi x0,x0,0 doubles as the pipeline bubble
	localparam wordT nop = 32'h0000_0013;

	// Decode/execute register
	typedef struct packed {
		logic valid;
		wordT pc;
		regAddrT rs1;
		regAddrT rs2;
		regAddrT rd;
		wordT operandA;
		wordT operandB;
		wordT imm;
		aluOpT aluOp;
		logic useImm;
		logic isLoad;
		logic isStore;
		logic isBranch;
		logic isJal;
		logic regWrite;
	} decodedT;

	// Execute/memory register, also the data port request
	typedef struct packed {
		logic valid;
		wordT result;
		wordT storeData;
		regAddrT rd;
		logic isLoad;
		logic isStore;
		logic regWrite;
	} executedT;

	typedef struct packed {
		logic enable;
		regAddrT rd;
		wordT data;
	} writebackT;

	typedef struct packed {
		logic valid;
		wordT target;
	} redirectT;

endpackage

// ==== design/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic clock,
	input logic reset,
	input corePkg::regAddrT readA,
	input corePkg::regAddrT readB,
	input corePkg::writebackT write,
	output corePkg::wordT dataA,
	output corePkg::wordT dataB
);

	corePkg::wordT registers [32];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 32; i++) begin
				registers[i] <= '0;
			end
		end else if (write.enable && write.rd != '0) begin
			registers[write.rd] <= write.data;
		end
	end

	// Same-cycle write shows up on the read ports
	assign dataA = (readA == '0) ? '0 :
		(write.enable && write.rd == readA) ? write.data : registers[readA];
	assign dataB = (readB == '0) ? '0 :
		(write.enable && write.rd == readB) ? write.data : registers[readB];

endmodule

// ==== design/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
	input logic clock,
	input logic reset,
	input logic freeze,
	input logic holdFront,
	input logic flushDecode,
	input corePkg::redirectT redirect,
	input corePkg::wordT instrData,
	output corePkg::wordT instrAddr,
	output corePkg::wordT fetchPc,
	output corePkg::wordT fetchInstr
);

	corePkg::wordT programCounter;
	corePkg::wordT nextPc;

	// A taken branch or jal from execute wins over sequential fetch
	assign nextPc = redirect.valid ? redirect.target : programCounter + 32'd4;
	assign instrAddr = programCounter;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			programCounter <= corePkg::resetPc;
		end else if (!freeze && !holdFront) begin
			programCounter <= nextPc;
		end
	end

	// Fetch/decode register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			fetchPc <= corePkg::resetPc;
			fetchInstr <= corePkg::nop;
		end else if (!freeze) begin
			if (flushDecode) begin
				// Wrong-path instruction becomes a bubble
				fetchInstr <= corePkg::nop;
			end else if (!holdFront) begin
				fetchPc <= programCounter;
				fetchInstr <= instrData;
			end
		end
	end

endmodule

// ==== design/decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit (
	input logic clock,
	input logic reset,
	input logic freeze,
	input logic bubbleExecute,
	input corePkg::wordT fetchPc,
	input corePkg::wordT fetchInstr,
	input corePkg::writebackT write,
	output corePkg::regAddrT sourceA,
	output corePkg::regAddrT sourceB,
	output corePkg::decodedT decoded
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	corePkg::regAddrT rs1;
	corePkg::regAddrT rs2;
	corePkg::regAddrT rd;
	corePkg::wordT immI;
	corePkg::wordT immS;
	corePkg::wordT immB;
	corePkg::wordT immJ;
	corePkg::wordT immediate;
	corePkg::wordT dataA;
	corePkg::wordT dataB;
	corePkg::aluOpT aluOp;
	logic known;
	logic usesA;
	logic usesB;
	logic useImm;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic isJal;
	logic writesRd;
	corePkg::decodedT nextDecoded;

	assign opcode = fetchInstr[6:0];
	assign funct3 = fetchInstr[14:12];
	assign funct7 = fetchInstr[31:25];
	assign rs1 = fetchInstr[19:15];
	assign rs2 = fetchInstr[24:20];
	assign rd = fetchInstr[11:7];

	assign immI = {{20{fetchInstr[31]}}, fetchInstr[31:20]};
	assign immS = {{20{fetchInstr[31]}}, fetchInstr[31:25], fetchInstr[11:7]};
	assign immB = {{19{fetchInstr[31]}}, fetchInstr[31], fetchInstr[7],
		fetchInstr[30:25], fetchInstr[11:8], 1'b0};
	assign immJ = {{11{fetchInstr[31]}}, fetchInstr[31], fetchInstr[19:12],
		fetchInstr[20], fetchInstr[30:21], 1'b0};

	always_comb begin
		known = 1'b1;
		usesA = 1'b0;
		usesB = 1'b0;
		useImm = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		writesRd = 1'b0;
		aluOp = corePkg::aluAdd;
		immediate = immI;
		case (opcode)
			corePkg::opRegReg: begin
				usesA = 1'b1;
				usesB = 1'b1;
				writesRd = 1'b1;
				case (funct3)
					3'b000: aluOp = funct7[5] ? corePkg::aluSub : corePkg::aluAdd;
					3'b010: aluOp = corePkg::aluSlt;
					3'b100: aluOp = corePkg::aluXor;
					3'b110: aluOp = corePkg::aluOr;
					3'b111: aluOp = corePkg::aluAnd;
					default: known = 1'b0;
				endcase
			end
			corePkg::opImm, corePkg::opLoad: begin
				usesA = 1'b1;
				useImm = 1'b1;
				writesRd = 1'b1;
				isLoad = (opcode == corePkg::opLoad);
			end
			corePkg::opStore: begin
				usesA = 1'b1;
				usesB = 1'b1;
				useImm = 1'b1;
				isStore = 1'b1;
				immediate = immS;
			end
			corePkg::opBranch: begin
				usesA = 1'b1;
				usesB = 1'b1;
				isBranch = 1'b1;
				immediate = immB;
			end
			corePkg::opJal: begin
				isJal = 1'b1;
				writesRd = 1'b1;
				immediate = immJ;
			end
			default: known = 1'b0;
		endcase
	end

	// Fields a format does not use never count as hazard sources
	assign sourceA = usesA ? rs1 : '0;
	assign sourceB = usesB ? rs2 : '0;

	registerFile u_registerFile (
		.clock(clock),
		.reset(reset),
		.readA(sourceA),
		.readB(sourceB),
		.write(write),
		.dataA(dataA),
		.dataB(dataB)
	);

	always_comb begin
		nextDecoded.valid = known;
		nextDecoded.pc = fetchPc;
		nextDecoded.rs1 = sourceA;
		nextDecoded.rs2 = sourceB;
		nextDecoded.rd = rd;
		nextDecoded.operandA = dataA;
		nextDecoded.operandB = dataB;
		nextDecoded.imm = immediate;
		nextDecoded.aluOp = aluOp;
		nextDecoded.useImm = useImm;
		nextDecoded.isLoad = known && isLoad;
		nextDecoded.isStore = known && isStore;
		nextDecoded.isBranch = known && isBranch;
		nextDecoded.isJal = known && isJal;
		// Writes to x0 are dropped here so forwarding never matches them
		nextDecoded.regWrite = known && writesRd && (rd != '0);
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			decoded <= '0;
		end else if (!freeze) begin
			decoded <= nextDecoded;
			if (bubbleExecute) begin
				decoded.valid <= 1'b0;
				decoded.isLoad <= 1'b0;
				decoded.isStore <= 1'b0;
				decoded.isBranch <= 1'b0;
				decoded.isJal <= 1'b0;
				decoded.regWrite <= 1'b0;
			end
		end
	end

endmodule

// ==== design/hazardControl.sv ====
`timescale 1ns/1ps

module hazardControl (
	input logic instrStall,
	input logic dataStall,
	input corePkg::decodedT decoded,
	input corePkg::regAddrT sourceA,
	input corePkg::regAddrT sourceB,
	input logic redirectValid,
	output logic freeze,
	output logic holdFront,
	output logic bubbleExecute,
	output logic flushDecode
);

	logic loadUse;

	// Load in execute feeding the instruction now in decode
	assign loadUse = decoded.valid && decoded.isLoad && (decoded.rd != '0) &&
		((decoded.rd == sourceA) || (decoded.rd == sourceB));

	// Either memory port stalling stops the whole pipeline
	assign freeze = instrStall || dataStall;

	// Priority is memory stall, then redirect, then load-use
	assign flushDecode = !freeze && redirectValid;
	assign bubbleExecute = !freeze && (redirectValid || loadUse);
	assign holdFront = !freeze && !redirectValid && loadUse;

endmodule

// ==== design/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
	input logic clock,
	input logic reset,
	input logic freeze,
	input corePkg::decodedT decoded,
	input corePkg::writebackT writeback,
	output corePkg::executedT executed,
	output corePkg::redirectT redirect
);

	corePkg::wordT operandA;
	corePkg::wordT operandB;
	corePkg::wordT aluB;
	corePkg::wordT aluResult;
	corePkg::wordT result;
	logic taken;

	// Newest producer first; a load in memory has no value yet
	function automatic corePkg::wordT forwardOperand(
		input corePkg::regAddrT source,
		input corePkg::wordT registered
	);
		corePkg::wordT value;
		value = registered;
		if (executed.valid && executed.regWrite && !executed.isLoad &&
				executed.rd == source) begin
			value = executed.result;
		end else if (writeback.enable && writeback.rd == source) begin
			value = writeback.data;
		end
		return value;
	endfunction

	assign operandA = forwardOperand(decoded.rs1, decoded.operandA);
	assign operandB = forwardOperand(decoded.rs2, decoded.operandB);
	assign aluB = decoded.useImm ? decoded.imm : operandB;

	always_comb begin
		case (decoded.aluOp)
			corePkg::aluSub: aluResult = operandA - aluB;
			corePkg::aluAnd: aluResult = operandA & aluB;
			corePkg::aluOr: aluResult = operandA | aluB;
			corePkg::aluXor: aluResult = operandA ^ aluB;
			corePkg::aluSlt: aluResult = {31'd0, $signed(operandA) < $signed(aluB)};
			default: aluResult = operandA + aluB;
		endcase
	end

	// jal links the return address
	assign result = decoded.isJal ? decoded.pc + 32'd4 : aluResult;

	assign taken = decoded.isJal || (decoded.isBranch && operandA == operandB);
	assign redirect.valid = decoded.valid && taken;
	assign redirect.target = decoded.pc + decoded.imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			executed <= '0;
		end else if (!freeze) begin
			executed.valid <= decoded.valid;
			executed.result <= result;
			executed.storeData <= operandB;
			executed.rd <= decoded.rd;
			executed.isLoad <= decoded.isLoad;
			executed.isStore <= decoded.isStore;
			executed.regWrite <= decoded.regWrite;
		end
	end

endmodule

// ==== design/resultUnit.sv ====
`timescale 1ns/1ps

module resultUnit (
	input logic clock,
	input logic reset,
	input logic freeze,
	input corePkg::executedT executed,
	input corePkg::wordT dataReadData,
	output corePkg::writebackT writeback
);

	logic writeValid;
	logic wasLoad;
	corePkg::regAddrT writeRd;
	corePkg::wordT aluResult;
	corePkg::wordT loadData;

	// Memory/writeback register, control part
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			writeValid <= 1'b0;
			wasLoad <= 1'b0;
			writeRd <= '0;
		end else if (!freeze) begin
			writeValid <= executed.valid && executed.regWrite;
			wasLoad <= executed.isLoad;
			writeRd <= executed.rd;
		end
	end

	always_ff @(posedge clock) begin
		if (!freeze) begin
			aluResult <= executed.result;
			loadData <= dataReadData;
		end
	end

	assign writeback.enable = writeValid;
	assign writeback.rd = writeRd;
	assign writeback.data = wasLoad ? loadData : aluResult;

endmodule

// ==== design/pipelineCore.sv ====
`timescale 1ns/1ps

module pipelineCore (
	input logic clock,
	input logic reset,
	input logic instrStall,
	input logic dataStall,
	input corePkg::wordT instrData,
	input corePkg::wordT dataReadData,
	output corePkg::wordT instrAddr,
	output corePkg::wordT dataAddr,
	output corePkg::wordT dataWriteData,
	output logic dataRead,
	output logic dataWrite
);

	logic freeze;
	logic holdFront;
	logic bubbleExecute;
	logic flushDecode;
	corePkg::wordT fetchPc;
	corePkg::wordT fetchInstr;
	corePkg::regAddrT sourceA;
	corePkg::regAddrT sourceB;
	corePkg::decodedT decoded;
	corePkg::executedT executed;
	corePkg::redirectT redirect;
	corePkg::writebackT writeback;

	fetchUnit u_fetchUnit (
		.clock(clock),
		.reset(reset),
		.freeze(freeze),
		.holdFront(holdFront),
		.flushDecode(flushDecode),
		.redirect(redirect),
		.instrData(instrData),
		.instrAddr(instrAddr),
		.fetchPc(fetchPc),
		.fetchInstr(fetchInstr)
	);

	decodeUnit u_decodeUnit (
		.clock(clock),
		.reset(reset),
		.freeze(freeze),
		.bubbleExecute(bubbleExecute),
		.fetchPc(fetchPc),
		.fetchInstr(fetchInstr),
		.write(writeback),
		.sourceA(sourceA),
		.sourceB(sourceB),
		.decoded(decoded)
	);

	hazardControl u_hazardControl (
		.instrStall(instrStall),
		.dataStall(dataStall),
		.decoded(decoded),
		.sourceA(sourceA),
		.sourceB(sourceB),
		.redirectValid(redirect.valid),
		.freeze(freeze),
		.holdFront(holdFront),
		.bubbleExecute(bubbleExecute),
		.flushDecode(flushDecode)
	);

	executeUnit u_executeUnit (
		.clock(clock),
		.reset(reset),
		.freeze(freeze),
		.decoded(decoded),
		.writeback(writeback),
		.executed(executed),
		.redirect(redirect)
	);

	resultUnit u_resultUnit (
		.clock(clock),
		.reset(reset),
		.freeze(freeze),
		.executed(executed),
		.dataReadData(dataReadData),
		.writeback(writeback)
	);

	// Data port straight from the registered execute/memory stage
	assign dataAddr = executed.result;
	assign dataWriteData = executed.storeData;
	assign dataRead = executed.valid && executed.isLoad;
	assign dataWrite = executed.valid && executed.isStore;

endmodule

// ==== sim/memoryModel.sv ====
`timescale 1ns/1ps

module memoryModel (
	input logic clock,
	input logic reset,
	input logic stallEnable,
	input corePkg::wordT instrAddr,
	input corePkg::wordT dataAddr,
	input corePkg::wordT dataWriteData,
	input logic dataRead,
	input logic dataWrite,
	output corePkg::wordT instrData,
	output corePkg::wordT dataReadData,
	output logic instrStall,
	output logic dataStall,
	output logic endSeen
);

	// Program words, written by the testbench before each run
	corePkg::wordT rom [64];
	corePkg::wordT ram [64];

	// Completed stores in the order the core made them
	corePkg::wordT logAddr [64];
	corePkg::wordT logData [64];
	int logCount;
	logic [31:0] seedState;

	// Junk while stalled, so a word taken too early shows up
	assign instrData = instrStall ? 32'hDEAD_BEEF : rom[instrAddr[7:2]];
	assign dataReadData = (dataStall || !dataRead) ? 32'hBAD0_BAD0 : ram[dataAddr[7:2]];

	always @(posedge clock or negedge reset) begin
		if (!reset) begin
			logCount <= 0;
			endSeen <= 1'b0;
			for (int i = 0; i < 64; i++) begin
				ram[i] <= 32'hA5C3_0000 | (i << 2);
			end
		end else if (dataWrite && !dataStall && !instrStall) begin
			// A store held by a fetch stall is counted once, when the core moves on
			ram[dataAddr[7:2]] <= dataWriteData;
			if (logCount < 64) begin
				logAddr[logCount[5:0]] <= dataAddr;
				logData[logCount[5:0]] <= dataWriteData;
			end
			logCount <= logCount + 1;
			if (dataAddr == 32'h0000_00FC) begin
				endSeen <= 1'b1;
			end
		end
	end

	// Random stalls on both ports
	initial begin
		seedState = $urandom(32'h5ef1);
		instrStall = 1'b0;
		dataStall = 1'b0;
		forever begin
			@(posedge clock);
			instrStall <= stallEnable && ($urandom % 4 == 0);
			dataStall <= stallEnable && ($urandom % 3 == 0);
		end
	end

endmodule

// ==== sim/coreTb.sv ====
`timescale 1ns/1ps

module coreTb;

	localparam int clockPeriod = 100;
	localparam int testRuns = 9;
	localparam int cycleLimit = 300;

	logic clock;
	logic reset;
	logic stallEnable;
	logic instrStall;
	logic dataStall;
	logic dataRead;
	logic dataWrite;
	logic endSeen;
	corePkg::wordT instrData;
	corePkg::wordT dataReadData;
	corePkg::wordT instrAddr;
	corePkg::wordT dataAddr;
	corePkg::wordT dataWriteData;

	corePkg::wordT expectAddr [32];
	corePkg::wordT expectData [32];
	int expectCount;
	int programSize;
	int mismatches;
	int otherErrors;

	pipelineCore u_pipelineCore (
		.clock(clock),
		.reset(reset),
		.instrStall(instrStall),
		.dataStall(dataStall),
		.instrData(instrData),
		.dataReadData(dataReadData),
		.instrAddr(instrAddr),
		.dataAddr(dataAddr),
		.dataWriteData(dataWriteData),
		.dataRead(dataRead),
		.dataWrite(dataWrite)
	);

	memoryModel memory (
		.clock(clock),
		.reset(reset),
		.stallEnable(stallEnable),
		.instrAddr(instrAddr),
		.dataAddr(dataAddr),
		.dataWriteData(dataWriteData),
		.dataRead(dataRead),
		.dataWrite(dataWrite),
		.instrData(instrData),
		.dataReadData(dataReadData),
		.instrStall(instrStall),
		.dataStall(dataStall),
		.endSeen(endSeen)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	initial begin
		#(testRuns * 400 * clockPeriod);
		$display("Watchdog expired before all tests finished");
		$display("TEST FAILED");
		$finish;
	end

	// RV32I encodings
	function automatic corePkg::wordT regOp(input logic [6:0] funct7, input logic [2:0] funct3,
		input int rd, input int rs1, input int rs2);
		return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
	endfunction

	function automatic corePkg::wordT addImm(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic corePkg::wordT loadWord(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic corePkg::wordT storeWord(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic corePkg::wordT branchEqual(input int rs1, input int rs2, input int offset);
		return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], 3'b000, offset[4:1], offset[11],
			7'b1100011};
	endfunction

	function automatic corePkg::wordT jumpLink(input int rd, input int offset);
		return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic compareWord(input string signal, input corePkg::wordT actual,
		input corePkg::wordT expected);
		assert (actual === expected) else begin
			mismatches++;
			$display("Mismatch %s: got %h, expected %h", signal, actual, expected);
		end
	endtask

	task automatic clearProgram();
		for (int i = 0; i < 64; i++) begin
			memory.rom[i[5:0]] = addImm(0, 0, 0);
		end
		programSize = 0;
		expectCount = 0;
	endtask

	task automatic emit(input corePkg::wordT word);
		memory.rom[programSize[5:0]] = word;
		programSize++;
	endtask

	task automatic expectStore(input corePkg::wordT addr, input corePkg::wordT data);
		expectAddr[expectCount[4:0]] = addr;
		expectData[expectCount[4:0]] = data;
		expectCount++;
	endtask

	// Store of x0 to the end-marker address closes every program
	task automatic finishProgram();
		emit(storeWord(0, 0, 'hFC));
		expectStore(32'h0000_00FC, 32'h0);
	endtask

	task automatic runProgram(input string name, input logic withStalls);
		int cycles;
		int shown;
		@(posedge clock);
		stallEnable <= withStalls;
		reset <= 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b1;
		cycles = 0;
		while (!endSeen && cycles < cycleLimit) begin
			@(negedge clock);
			cycles++;
		end
		assert (endSeen) else begin
			otherErrors++;
			$display("%s: no store to the end marker within %0d cycles", name, cycleLimit);
		end
		assert (memory.logCount == expectCount) else begin
			otherErrors++;
			$display("%s: %0d stores seen, %0d expected", name, memory.logCount, expectCount);
		end
		shown = (memory.logCount < expectCount) ? memory.logCount : expectCount;
		for (int i = 0; i < shown; i++) begin
			compareWord($sformatf("%s store %0d dataAddr", name, i),
				memory.logAddr[i[5:0]], expectAddr[i[4:0]]);
			compareWord($sformatf("%s store %0d dataWriteData", name, i),
				memory.logData[i[5:0]], expectData[i[4:0]]);
		end
	endtask

	task automatic resetState();
		clearProgram();
		@(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		compareWord("dataRead in reset", {31'd0, dataRead}, 32'h0);
		compareWord("dataWrite in reset", {31'd0, dataWrite}, 32'h0);
		compareWord("instrAddr in reset", instrAddr, 32'h0);
		repeat (2) @(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		compareWord("instrAddr after reset", instrAddr, 32'h0);
		compareWord("dataRead after reset", {31'd0, dataRead}, 32'h0);
		compareWord("dataWrite after reset", {31'd0, dataWrite}, 32'h0);
	endtask

	task automatic arithmeticOps(input logic withStalls);
		int a;
		int b;
		a = 1234;
		b = -567;
		clearProgram();
		emit(addImm(1, 0, a));
		emit(addImm(2, 0, b));
		emit(regOp(7'h00, 3'b000, 3, 1, 2));
		emit(regOp(7'h20, 3'b000, 4, 1, 2));
		emit(regOp(7'h00, 3'b111, 5, 1, 2));
		emit(regOp(7'h00, 3'b110, 6, 1, 2));
		emit(regOp(7'h00, 3'b100, 7, 1, 2));
		// slt both ways round
		emit(regOp(7'h00, 3'b010, 8, 2, 1));
		emit(regOp(7'h00, 3'b010, 9, 1, 2));
		emit(addImm(10, 1, -2000));
		for (int r = 3; r <= 10; r++) begin
			emit(storeWord(r, 0, 'h40 + 4 * (r - 3)));
		end
		expectStore(32'h40, a + b);
		expectStore(32'h44, a - b);
		expectStore(32'h48, a & b);
		expectStore(32'h4C, a | b);
		expectStore(32'h50, a ^ b);
		expectStore(32'h54, (b < a) ? 1 : 0);
		expectStore(32'h58, (a < b) ? 1 : 0);
		expectStore(32'h5C, a - 2000);
		finishProgram();
		runProgram(withStalls ? "arith stalled" : "arith", withStalls);
	endtask

	task automatic forwardingChain(input logic withStalls);
		int value [16];
		value[1] = 677;
		value[2] = value[1] + value[1];
		value[3] = value[2] - value[1];
		value[4] = value[3] ^ value[2];
		value[5] = value[4] | value[1];
		value[6] = value[5] - 3;
		value[7] = value[6] & value[3];
		value[8] = value[7] + value[6];
		clearProgram();
		// Each result feeds the next one at once
		emit(addImm(1, 0, value[1]));
		emit(regOp(7'h00, 3'b000, 2, 1, 1));
		emit(regOp(7'h20, 3'b000, 3, 2, 1));
		emit(regOp(7'h00, 3'b100, 4, 3, 2));
		emit(regOp(7'h00, 3'b110, 5, 4, 1));
		emit(addImm(6, 5, -3));
		emit(regOp(7'h00, 3'b111, 7, 6, 3));
		emit(regOp(7'h00, 3'b000, 8, 7, 6));
		// Base from the memory stage, x8 from writeback
		emit(addImm(9, 0, 'h60));
		for (int r = 8; r >= 2; r--) begin
			emit(storeWord(r, 9, 4 * (8 - r)));
			expectStore('h60 + 4 * (8 - r), value[r[3:0]]);
		end
		finishProgram();
		runProgram(withStalls ? "forward stalled" : "forward", withStalls);
	endtask

	task automatic loadUse(input logic withStalls);
		int first;
		int second;
		first = 300;
		second = -45;
		clearProgram();
		emit(addImm(1, 0, first));
		emit(addImm(2, 0, 'h80));
		emit(storeWord(1, 2, 0));
		emit(addImm(3, 0, second));
		emit(storeWord(3, 2, 4));
		// Consumers right behind their loads
		emit(loadWord(4, 2, 0));
		emit(regOp(7'h00, 3'b000, 5, 4, 1));
		emit(loadWord(6, 2, 4));
		emit(regOp(7'h00, 3'b000, 7, 1, 6));
		emit(loadWord(8, 2, 0));
		emit(storeWord(8, 2, 8));
		emit(storeWord(5, 2, 12));
		emit(storeWord(7, 2, 16));
		emit(loadWord(9, 2, 16));
		emit(addImm(10, 9, 1));
		emit(storeWord(10, 2, 20));
		expectStore(32'h80, first);
		expectStore(32'h84, second);
		expectStore(32'h88, first);
		expectStore(32'h8C, first + first);
		expectStore(32'h90, first + second);
		expectStore(32'h94, first + second + 1);
		finishProgram();
		runProgram(withStalls ? "load stalled" : "load", withStalls);
	endtask

	task automatic branchesAndJal(input logic withStalls);
		int left;
		int right;
		int other;
		int jalPc;
		left = 7;
		right = 7;
		other = 9;
		clearProgram();
		emit(addImm(1, 0, left));
		emit(addImm(2, 0, right));
		emit(addImm(3, 0, other));
		emit(branchEqual(1, 2, 12));
		emit(storeWord(1, 0, 'hA0));
		emit(storeWord(2, 0, 'hA4));
		emit(branchEqual(1, 3, 8));
		emit(storeWord(3, 0, 'hA8));
		jalPc = programSize * 4;
		emit(jumpLink(5, 12));
		emit(storeWord(1, 0, 'hAC));
		emit(storeWord(2, 0, 'hB0));
		emit(storeWord(5, 0, 'hB4));
		if (left != right) begin
			expectStore(32'hA0, left);
			expectStore(32'hA4, right);
		end
		if (left != other) begin
			expectStore(32'hA8, other);
		end
		// Link value of the jal
		expectStore(32'hB4, jalPc + 4);
		finishProgram();
		runProgram(withStalls ? "branch stalled" : "branch", withStalls);
	endtask

	initial begin
		reset = 1'b0;
		stallEnable = 1'b0;
		mismatches = 0;
		otherErrors = 0;
		expectCount = 0;
		programSize = 0;
		resetState();
		arithmeticOps(1'b0);
		forwardingChain(1'b0);
		loadUse(1'b0);
		branchesAndJal(1'b0);
		arithmeticOps(1'b1);
		forwardingChain(1'b1);
		loadUse(1'b1);
		branchesAndJal(1'b1);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
design/corePkg.sv
design/registerFile.sv
design/fetchUnit.sv
design/decodeUnit.sv
design/hazardControl.sv
design/executeUnit.sv
design/resultUnit.sv
design/pipelineCore.sv
sim/memoryModel.sv
sim/coreTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module coreTb -o coreSim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/coreSim > sim.log 2>&1 \
	&& ! grep -q "TEST FAILED" sim.log \
	&& { cat sim.log; echo "Simulation passed"; } \
	|| { cat sim.log; echo "Simulation failed"; exit 1; }
